/* filelist.f */
verilog/board_pkg.sv
verilog/debug_regs_pkg.sv
verilog/debug_apb_regs.sv
verilog/lcd_char_driver.sv
verilog/board_indicators.sv
verilog/debug_display_top.sv
test/tb_debug_display.sv

/* Bender.yml */
package:
  name: debug_display

sources:
  - files:
      - verilog/board_pkg.sv
      - verilog/debug_regs_pkg.sv
      - verilog/debug_apb_regs.sv
      - verilog/lcd_char_driver.sv
      - verilog/board_indicators.sv
      - verilog/debug_display_top.sv
  - target: test
    files:
      - test/tb_debug_display.sv

/* test/tb_debug_display.sv */
// Short LCD step (2) and heartbeat (16) timing; APB slave assumed zero-wait, 8 ns clock
module tb_debug_display;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int APB_TIMEOUT = 20;
    localparam int LCD_TIMEOUT = 200;
    localparam int DATA_WORDS  = debug_regs_pkg::DATA_WORDS;

    logic        clock_50;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [17:0] sw;
    logic [7:0]  lcd_data;
    logic        lcd_en;
    logic        lcd_rs;
    logic        lcd_rw;
    logic        lcd_on;
    logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
    logic [17:0] ledr;
    logic [8:0]  ledg;

    // Expected values and bookkeeping
    logic [31:0] shadow [DATA_WORDS];
    logic [31:0] rd_exp;
    logic        err_exp;
    logic        ind_check;
    logic [55:0] hex_exp;
    logic [17:0] ledr_exp;
    logic [7:0]  ledg_exp;
    integer      seed;
    int          errors;
    int          err_base;
    int          tests_run;
    int          tests_failed;

    // Active-low segments, a in bit 0
    logic [6:0] seg_table [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                   7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

    debug_display_top #(
        .LCD_STEP_CYCLES  (2),
        .HEARTBEAT_CYCLES (16)
    ) u_debug_display_top (.*);

    initial begin
        clock_50 = 1'b0;
        forever #4 clock_50 = ~clock_50;
    end

    // ============================================================
    // Checkers
    // ============================================================
    task automatic note_error(input string msg);
        errors++;
        $display("FAIL t=%0t: %s", $time, msg);
    endtask

    assert property (@(posedge clock_50) disable iff (reset)
        (psel && penable) |-> (pready && pslverr == err_exp && (pwrite || prdata == rd_exp)))
    else note_error($sformatf("APB addr %h: prdata %h pslverr %b, expected %h %b",
        $sampled(paddr), $sampled(prdata), $sampled(pslverr), rd_exp, err_exp));

    assert property (@(posedge clock_50) disable iff (reset)
        ind_check |-> ({hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0} == hex_exp
                       && ledr == ledr_exp && ledg[7:0] == ledg_exp))
    else note_error($sformatf("indicators: hex %h ledr %h ledg %h, expected %h %h %h",
        $sampled({hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0}), $sampled(ledr),
        $sampled(ledg[7:0]), hex_exp, ledr_exp, ledg_exp));

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'd48 + 8'(nib);
        end
        return 8'd55 + 8'(nib);
    endfunction

    function automatic logic [127:0] expected_page(input int page);
        logic [127:0] value;
        value = '0;
        if (page < debug_regs_pkg::PAGE_COUNT) begin
            for (int w = 0; w < 4; w++) begin
                value[w*32 +: 32] = shadow[page*4 + w];
            end
        end
        return value;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s at t=%0t", what, $time);
        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed + 1, errors);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors > err_base) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_base);
        end else begin
            $display("test %s: passed", name);
        end
        err_base = errors;
    endtask

    // ============================================================
    // Bus and LCD helpers
    // ============================================================
    task automatic apb_access(input logic write, input int word, input logic [31:0] data);
        int n;
        @(negedge clock_50);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = {6'(word), 2'($random(seed))};
        pwdata  = data;
        err_exp = (word >= debug_regs_pkg::REG_COUNT);
        rd_exp  = (word < DATA_WORDS) ? shadow[word] : 32'h0;
        if (write && word < DATA_WORDS) begin
            shadow[word] = data;
        end
        @(negedge clock_50);
        penable = 1'b1;
        n = 0;
        while (!pready && n < APB_TIMEOUT) begin
            @(negedge clock_50);
            n++;
        end
        if (!pready) stop_on_timeout("APB pready");
        @(negedge clock_50);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic next_lcd_byte(output logic [7:0] data, output logic rs);
        logic prev_en;
        logic seen;
        int   n;
        prev_en = lcd_en;
        seen    = 1'b0;
        n       = 0;
        while (!seen && n < LCD_TIMEOUT) begin
            @(negedge clock_50);
            seen    = lcd_en && !prev_en;
            prev_en = lcd_en;
            n++;
        end
        if (!seen) stop_on_timeout("an LCD enable pulse");
        data = lcd_data;
        rs   = lcd_rs;
    endtask

    task automatic check_page_text(input int page);
        logic [127:0] text;
        logic [7:0]   data;
        logic         rs;
        int           c;
        int           n;
        text = expected_page(page);
        @(negedge clock_50);
        sw[board_pkg::PAGE_SEL_LSB +: 4] = 4'(page);
        data = 8'h00;
        rs   = 1'b1;
        n    = 0;
        while (!(data == 8'h80 && !rs) && n < 40) begin
            next_lcd_byte(data, rs);
            n++;
        end
        if (!(data == 8'h80 && !rs)) stop_on_timeout("the LCD frame start");
        c = 0;
        n = 0;
        while (c < 32 && n < 40) begin
            next_lcd_byte(data, rs);
            n++;
            if (rs) begin
                assert (data == hex_char(text[(31-c)*4 +: 4]))
                else note_error($sformatf("page %0d char %0d is %h", page, c, data));
                c++;
            end
        end
        assert (c == 32) else note_error($sformatf("frame held only %0d characters", c));
    endtask

    task automatic show_value(input logic sel, input logic [31:0] value);
        @(negedge clock_50);
        sw[board_pkg::VALUE_SEL_BIT] = sel;
        for (int k = 0; k < 8; k++) begin
            hex_exp[k*7 +: 7] = seg_table[value[k*4 +: 4]];
        end
        @(negedge clock_50);
        ind_check = 1'b1;
        repeat (3) @(negedge clock_50);
        ind_check = 1'b0;
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin
        logic [8'd7:0] cmds [5];
        logic [7:0]    data;
        logic          rs;
        logic [31:0]   len;
        logic [31:0]   id;
        logic [31:0]   stat;
        logic          hb_start;
        logic          toggled;
        int            n;
        cmds = '{8'h38, 8'h0C, 8'h01, 8'h06, 8'h80};
        seed = 32'h3324456d;
        {errors, err_base, tests_run, tests_failed} = '0;
        reset = 1'b1;
        {psel, penable, pwrite, ind_check, err_exp} = '0;
        paddr  = '0;
        pwdata = '0;
        rd_exp = '0;
        sw     = '0;
        shadow = '{default: '0};
        repeat (10) @(negedge clock_50);
        assert (!lcd_en && !lcd_rs && !lcd_rw && lcd_on && ledr == 0 && ledg[7:0] == 0
                && {hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0} == {8{7'h40}})
        else note_error("outputs not at their reset values");
        reset = 1'b0;
        for (int w = 0; w < debug_regs_pkg::REG_COUNT; w++) apb_access(1'b0, w, 32'h0);
        finish_test("reset state");

        for (int w = 0; w < DATA_WORDS; w++) apb_access(1'b1, w, $random(seed));
        for (int w = 0; w < DATA_WORDS; w++) apb_access(1'b0, w, 32'h0);
        apb_access(1'b1, 60, $random(seed));
        apb_access(1'b0, 60, 32'h0);
        finish_test("apb access");

        check_page_text(7);
        check_page_text(13);
        finish_test("lcd page text");

        apb_access(1'b1, debug_regs_pkg::ADDR_CONTROL, 32'h1);
        for (int i = 0; i < 5; i++) begin
            next_lcd_byte(data, rs);
            assert (data == cmds[i] && !rs)
            else note_error($sformatf("command %0d is %h rs %b", i, data, rs));
        end
        for (int i = 0; i < 16; i++) begin
            next_lcd_byte(data, rs);
            assert (rs) else note_error($sformatf("byte %0d of line 1 is a command", i));
        end
        next_lcd_byte(data, rs);
        assert (data == 8'hC0 && !rs) else note_error($sformatf("line 2 command is %h", data));
        finish_test("lcd sequencing");

        len  = $random(seed);
        id   = $random(seed);
        stat = $random(seed);
        apb_access(1'b1, debug_regs_pkg::ADDR_SUBJECT_LENGTH, len);
        apb_access(1'b1, debug_regs_pkg::ADDR_SUBJECT_ID, id);
        apb_access(1'b1, debug_regs_pkg::ADDR_STATUS, stat);
        ledr_exp = stat[25:8];
        ledg_exp = stat[7:0];
        show_value(1'b0, len);
        show_value(1'b1, id);
        finish_test("indicators");

        hb_start = ledg[8];
        toggled  = 1'b0;
        n        = 0;
        while (!toggled && n < 40) begin
            @(negedge clock_50);
            toggled = (ledg[8] != hb_start);
            n++;
        end
        assert (toggled) else note_error("heartbeat did not toggle within 40 cycles");
        finish_test("heartbeat");

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/debug_display_top.sv */
// Debug display top; host access over APB only, single 50 MHz clock domain with synchronous reset
module debug_display_top #(
    parameter int LCD_STEP_CYCLES  = board_pkg::LCD_STEP_CYCLES_DEFAULT,
    parameter int HEARTBEAT_CYCLES = board_pkg::HEARTBEAT_CYCLES_DEFAULT
) (
    input  logic                                      clock_50,
    input  logic                                      reset,
    // APB slave
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [debug_regs_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [debug_regs_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [debug_regs_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    // Board
    input  logic [board_pkg::SW_WIDTH-1:0]            sw,
    output logic [board_pkg::LCD_DATA_WIDTH-1:0]      lcd_data,
    output logic                                      lcd_en,
    output logic                                      lcd_rs,
    output logic                                      lcd_rw,
    output logic                                      lcd_on,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex0,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex1,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex2,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex3,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex4,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex5,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex6,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex7,
    output logic [board_pkg::LEDR_WIDTH-1:0]          ledr,
    output logic [board_pkg::LEDG_WIDTH-1:0]          ledg
);

    logic [debug_regs_pkg::PAGE_WIDTH-1:0]     page_data;
    logic [debug_regs_pkg::APB_DATA_WIDTH-1:0] subject_length;
    logic [debug_regs_pkg::APB_DATA_WIDTH-1:0] subject_id;
    logic [debug_regs_pkg::STATUS_WIDTH-1:0]   status;
    logic                                      refresh;

    debug_apb_regs u_regs (
        .clock_50       (clock_50),
        .reset          (reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .page_sel       (sw[board_pkg::PAGE_SEL_LSB +: debug_regs_pkg::PAGE_SEL_WIDTH]),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .page_data      (page_data),
        .subject_length (subject_length),
        .subject_id     (subject_id),
        .status         (status),
        .refresh        (refresh)
    );

    lcd_char_driver #(
        .STEP_CYCLES (LCD_STEP_CYCLES)
    ) u_lcd (
        .clock_50  (clock_50),
        .reset     (reset),
        .refresh   (refresh),
        .page_data (page_data),
        .lcd_data  (lcd_data),
        .lcd_en    (lcd_en),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_on    (lcd_on)
    );

    board_indicators #(
        .HEARTBEAT_CYCLES (HEARTBEAT_CYCLES)
    ) u_indicators (
        .clock_50       (clock_50),
        .reset          (reset),
        .sw             (sw),
        .subject_length (subject_length),
        .subject_id     (subject_id),
        .status         (status),
        .hex0           (hex0),
        .hex1           (hex1),
        .hex2           (hex2),
        .hex3           (hex3),
        .hex4           (hex4),
        .hex5           (hex5),
        .hex6           (hex6),
        .hex7           (hex7),
        .ledr           (ledr),
        .ledg           (ledg)
    );

endmodule

/* verilog/board_indicators.sv */
// Seven-segment digits are active low with segment a in bit 0; outputs lag their inputs by one cycle
module board_indicators #(
    parameter int HEARTBEAT_CYCLES = board_pkg::HEARTBEAT_CYCLES_DEFAULT
) (
    input  logic                                      clock_50,
    input  logic                                      reset,
    input  logic [board_pkg::SW_WIDTH-1:0]            sw,
    input  logic [debug_regs_pkg::APB_DATA_WIDTH-1:0] subject_length,
    input  logic [debug_regs_pkg::APB_DATA_WIDTH-1:0] subject_id,
    input  logic [debug_regs_pkg::STATUS_WIDTH-1:0]   status,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex0,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex1,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex2,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex3,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex4,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex5,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex6,
    output logic [board_pkg::SEG_WIDTH-1:0]           hex7,
    output logic [board_pkg::LEDR_WIDTH-1:0]          ledr,
    output logic [board_pkg::LEDG_WIDTH-1:0]          ledg
);

    localparam int              HB_W    = $clog2(HEARTBEAT_CYCLES + 1);
    localparam logic [HB_W-1:0] HB_LAST = HB_W'(HEARTBEAT_CYCLES - 1);

    logic [board_pkg::SEG_WIDTH-1:0]          hex_q [board_pkg::HEX_DIGITS];
    logic [debug_regs_pkg::APB_DATA_WIDTH-1:0] shown;
    logic [board_pkg::LEDG_WIDTH-2:0]         ledg_low;
    logic [HB_W-1:0]                          hb_cnt;
    logic                                     heartbeat;

    function automatic logic [board_pkg::SEG_WIDTH-1:0] seg7(input logic [3:0] nib);
        case (nib)
            4'h0: seg7 = 7'h40;
            4'h1: seg7 = 7'h79;
            4'h2: seg7 = 7'h24;
            4'h3: seg7 = 7'h30;
            4'h4: seg7 = 7'h19;
            4'h5: seg7 = 7'h12;
            4'h6: seg7 = 7'h02;
            4'h7: seg7 = 7'h78;
            4'h8: seg7 = 7'h00;
            4'h9: seg7 = 7'h10;
            4'hA: seg7 = 7'h08;
            4'hB: seg7 = 7'h03;
            4'hC: seg7 = 7'h46;
            4'hD: seg7 = 7'h21;
            4'hE: seg7 = 7'h06;
            default: seg7 = 7'h0E;
        endcase
    endfunction

    // ID when the switch is up, length otherwise
    assign shown = sw[board_pkg::VALUE_SEL_BIT] ? subject_id : subject_length;

    always_ff @(posedge clock_50) begin
        if (reset) begin
            for (int k = 0; k < board_pkg::HEX_DIGITS; k++) begin
                hex_q[k] <= seg7(4'h0);
            end
            ledr     <= '0;
            ledg_low <= '0;
        end else begin
            for (int k = 0; k < board_pkg::HEX_DIGITS; k++) begin
                hex_q[k] <= seg7(shown[k*4 +: 4]);
            end
            // Upper status bits on red, lower on green
            ledr     <= status[debug_regs_pkg::STATUS_WIDTH-1 -: board_pkg::LEDR_WIDTH];
            ledg_low <= status[board_pkg::LEDG_WIDTH-2:0];
        end
    end

    // Heartbeat toggles every HEARTBEAT_CYCLES cycles
    always_ff @(posedge clock_50) begin
        if (reset) begin
            hb_cnt    <= '0;
            heartbeat <= 1'b0;
        end else if (hb_cnt == HB_LAST) begin
            hb_cnt    <= '0;
            heartbeat <= ~heartbeat;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];
    assign hex4 = hex_q[4];
    assign hex5 = hex_q[5];
    assign hex6 = hex_q[6];
    assign hex7 = hex_q[7];
    assign ledg = {heartbeat, ledg_low};

endmodule

/* verilog/lcd_char_driver.sv */
// Write-only HD44780 sequencer; data and RS change with the rising enable edge, latched on the fall
module lcd_char_driver #(
    parameter int STEP_CYCLES = board_pkg::LCD_STEP_CYCLES_DEFAULT
) (
    input  logic                                  clock_50,
    input  logic                                  reset,
    input  logic                                  refresh,
    input  logic [debug_regs_pkg::PAGE_WIDTH-1:0] page_data,
    output logic [board_pkg::LCD_DATA_WIDTH-1:0]  lcd_data,
    output logic                                  lcd_en,
    output logic                                  lcd_rs,
    output logic                                  lcd_rw,
    output logic                                  lcd_on
);

    localparam int                STEP_W    = $clog2(STEP_CYCLES + 1);
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(STEP_CYCLES - 1);

    typedef enum logic {
        ST_EN_LOW,
        ST_EN_HIGH
    } phase_t;

    phase_t                                   state;
    logic [STEP_W-1:0]                        phase_cnt;
    logic [board_pkg::LCD_IDX_WIDTH-1:0]      byte_idx;
    logic [board_pkg::LCD_DATA_WIDTH-1:0]     next_byte;
    logic                                     next_rs;
    logic [4:0]                               char_pos;
    logic [3:0]                               nibble;

    function automatic logic [board_pkg::LCD_DATA_WIDTH-1:0] hex_ascii(input logic [3:0] nib);
        hex_ascii = (nib >= 4'hA) ? {4'h4, nib - 4'h9} : {4'h3, nib};
    endfunction

    // ============================================================
    // Byte selection
    // ============================================================
    // Character c shows nibble 31-c, so the top line starts at the MSBs
    assign nibble = page_data[{~char_pos, 2'b00} +: 4];

    always_comb begin
        next_byte = board_pkg::LCD_CMD_ENTRY;
        next_rs   = 1'b0;
        char_pos  = '0;
        if (byte_idx < board_pkg::LCD_IDX_LINE1) begin
            case (byte_idx[1:0])
                2'd0:    next_byte = board_pkg::LCD_CMD_FUNC_SET;
                2'd1:    next_byte = board_pkg::LCD_CMD_DISP_ON;
                2'd2:    next_byte = board_pkg::LCD_CMD_CLEAR;
                default: next_byte = board_pkg::LCD_CMD_ENTRY;
            endcase
        end else if (byte_idx == board_pkg::LCD_IDX_LINE1) begin
            next_byte = board_pkg::LCD_CMD_LINE1;
        end else if (byte_idx == board_pkg::LCD_IDX_LINE2) begin
            next_byte = board_pkg::LCD_CMD_LINE2;
        end else begin
            if (byte_idx < board_pkg::LCD_IDX_LINE2) begin
                char_pos = 5'(byte_idx - (board_pkg::LCD_IDX_LINE1 + 1));
            end else begin
                char_pos = 5'(byte_idx - (board_pkg::LCD_IDX_LINE2 + 1)
                              + board_pkg::LCD_LINE_CHARS);
            end
            next_rs   = 1'b1;
            next_byte = hex_ascii(nibble);
        end
    end

    // ============================================================
    // Enable pulse sequencer
    // ============================================================
    // Each byte is STEP_CYCLES high then STEP_CYCLES low
    always_ff @(posedge clock_50) begin
        if (reset || refresh) begin
            state     <= ST_EN_LOW;
            phase_cnt <= '0;
            byte_idx  <= '0;
            lcd_en    <= 1'b0;
            lcd_rs    <= 1'b0;
            lcd_data  <= '0;
        end else begin
            case (state)
                ST_EN_LOW: begin
                    if (phase_cnt == STEP_LAST) begin
                        phase_cnt <= '0;
                        lcd_data  <= next_byte;
                        lcd_rs    <= next_rs;
                        lcd_en    <= 1'b1;
                        state     <= ST_EN_HIGH;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                ST_EN_HIGH: begin
                    if (phase_cnt == STEP_LAST) begin
                        phase_cnt <= '0;
                        lcd_en    <= 1'b0;
                        state     <= ST_EN_LOW;
                        // Init runs once, the frame repeats
                        if (byte_idx == board_pkg::LCD_IDX_LAST) begin
                            byte_idx <= board_pkg::LCD_IDX_WIDTH'(board_pkg::LCD_IDX_LINE1);
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                default: state <= ST_EN_LOW;
            endcase
        end
    end

    // Display is only ever written
    assign lcd_rw = 1'b0;
    assign lcd_on = 1'b1;

endmodule

/* verilog/debug_apb_regs.sv */
// Zero-wait APB slave; paddr[1:0] ignored, control word is write-only and reads as zero
module debug_apb_regs (
    input  logic                                      clock_50,
    input  logic                                      reset,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [debug_regs_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [debug_regs_pkg::APB_DATA_WIDTH-1:0] pwdata,
    input  logic [debug_regs_pkg::PAGE_SEL_WIDTH-1:0] page_sel,
    output logic [debug_regs_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    output logic [debug_regs_pkg::PAGE_WIDTH-1:0]     page_data,
    output logic [debug_regs_pkg::APB_DATA_WIDTH-1:0] subject_length,
    output logic [debug_regs_pkg::APB_DATA_WIDTH-1:0] subject_id,
    output logic [debug_regs_pkg::STATUS_WIDTH-1:0]   status,
    output logic                                      refresh
);

    logic [debug_regs_pkg::APB_DATA_WIDTH-1:0]  regs [debug_regs_pkg::DATA_WORDS];
    logic [debug_regs_pkg::WORD_ADDR_WIDTH-1:0] word_addr;
    logic [debug_regs_pkg::WORD_ADDR_WIDTH-1:0] page_base;
    logic                                       access;
    logic                                       addr_valid;
    logic                                       wr_en;

    // ============================================================
    // APB decode
    // ============================================================
    assign word_addr  = paddr[debug_regs_pkg::APB_ADDR_WIDTH-1:2];
    assign access     = psel & penable;
    assign addr_valid = word_addr < debug_regs_pkg::REG_COUNT;
    assign wr_en      = access & pwrite & addr_valid;

    assign pready  = 1'b1;
    assign pslverr = access & ~addr_valid;

    // Control word and unmapped words read as zero
    always_comb begin
        prdata = '0;
        if (word_addr < debug_regs_pkg::DATA_WORDS) begin
            prdata = regs[word_addr];
        end
    end

    // Write at the access-phase edge
    always_ff @(posedge clock_50) begin
        if (reset) begin
            regs    <= '{default: '0};
            refresh <= 1'b0;
        end else begin
            refresh <= wr_en && (word_addr == debug_regs_pkg::ADDR_CONTROL)
                       && pwdata[debug_regs_pkg::CTRL_REFRESH_BIT];
            if (wr_en && (word_addr < debug_regs_pkg::DATA_WORDS)) begin
                regs[word_addr] <= pwdata;
            end
        end
    end

    // ============================================================
    // Page read-out and indicator values
    // ============================================================
    assign page_base = debug_regs_pkg::WORD_ADDR_WIDTH'(
        page_sel * debug_regs_pkg::WORDS_PER_PAGE);

    // One cycle behind page_sel; pages past the last one are blank
    always_ff @(posedge clock_50) begin
        if (reset) begin
            page_data <= '0;
        end else begin
            for (int w = 0; w < debug_regs_pkg::WORDS_PER_PAGE; w++) begin
                page_data[w*debug_regs_pkg::APB_DATA_WIDTH +: debug_regs_pkg::APB_DATA_WIDTH] <=
                    (page_sel < debug_regs_pkg::PAGE_COUNT) ? regs[page_base + w] : '0;
            end
        end
    end

    assign subject_length = regs[debug_regs_pkg::ADDR_SUBJECT_LENGTH];
    assign subject_id     = regs[debug_regs_pkg::ADDR_SUBJECT_ID];
    assign status         = regs[debug_regs_pkg::ADDR_STATUS][debug_regs_pkg::STATUS_WIDTH-1:0];

endmodule

/* verilog/debug_regs_pkg.sv */
// Debug register map for a 256-byte APB window; word aligned, byte strobes are not supported
package debug_regs_pkg;

    // ============================================================
    // APB bus
    // ============================================================
    localparam int APB_ADDR_WIDTH  = 8;
    localparam int APB_DATA_WIDTH  = 32;
    localparam int WORD_ADDR_WIDTH = APB_ADDR_WIDTH - 2;

    // ============================================================
    // Page layout
    // ============================================================
    // Page p is words 4p..4p+3, highest word in the top bits
    localparam int WORDS_PER_PAGE = 4;
    localparam int PAGE_COUNT     = 13;
    localparam int PAGE_WIDTH     = WORDS_PER_PAGE * APB_DATA_WIDTH;
    localparam int PAGE_SEL_WIDTH = 4;

    // Pages 0-2 query data, 3-5 subject data, 6 general debug,
    // 7-9 query debug, 10-12 subject debug

    // ============================================================
    // Register map, in word addresses
    // ============================================================
    localparam int REG_COUNT           = 56;
    localparam int ADDR_SUBJECT_LENGTH = 52;
    localparam int ADDR_SUBJECT_ID     = 53;
    localparam int ADDR_STATUS         = 54;
    localparam int ADDR_CONTROL        = 55;

    // Words below the control word are stored
    localparam int DATA_WORDS = ADDR_CONTROL;

    localparam int STATUS_WIDTH     = 26;
    localparam int CTRL_REFRESH_BIT = 0;

endpackage

/* verilog/board_pkg.sv */
// Board constants for a 50 MHz clock; LCD timing assumes an HD44780 needing about 40 us per bus phase
package board_pkg;

    // ============================================================
    // Clock and board I/O widths
    // ============================================================
    localparam int CLOCK_HZ       = 50_000_000;
    localparam int SW_WIDTH       = 18;
    localparam int LEDR_WIDTH     = 18;
    localparam int LEDG_WIDTH     = 9;
    localparam int SEG_WIDTH      = 7;   // segments g..a, active low
    localparam int HEX_DIGITS     = 8;
    localparam int LCD_DATA_WIDTH = 8;

    // Switch fields
    localparam int PAGE_SEL_LSB  = 14;
    localparam int VALUE_SEL_BIT = 10;

    // Timing defaults, 40 us per LCD phase and 0.5 s per heartbeat toggle
    localparam int LCD_STEP_CYCLES_DEFAULT  = CLOCK_HZ / 25_000;
    localparam int HEARTBEAT_CYCLES_DEFAULT = CLOCK_HZ / 2;

    // ============================================================
    // LCD command set and byte sequence
    // ============================================================
    localparam logic [LCD_DATA_WIDTH-1:0] LCD_CMD_FUNC_SET = 8'h38;
    localparam logic [LCD_DATA_WIDTH-1:0] LCD_CMD_DISP_ON  = 8'h0C;
    localparam logic [LCD_DATA_WIDTH-1:0] LCD_CMD_CLEAR    = 8'h01;
    localparam logic [LCD_DATA_WIDTH-1:0] LCD_CMD_ENTRY    = 8'h06;
    localparam logic [LCD_DATA_WIDTH-1:0] LCD_CMD_LINE1    = 8'h80;
    localparam logic [LCD_DATA_WIDTH-1:0] LCD_CMD_LINE2    = 8'hC0;

    localparam int LCD_LINE_CHARS = 16;
    // Bytes 0..3 are init, then line 1 address, 16 chars, line 2 address, 16 chars
    localparam int LCD_IDX_LINE1  = 4;
    localparam int LCD_IDX_LINE2  = LCD_IDX_LINE1 + LCD_LINE_CHARS + 1;
    localparam int LCD_IDX_LAST   = LCD_IDX_LINE2 + LCD_LINE_CHARS;
    localparam int LCD_IDX_WIDTH  = $clog2(LCD_IDX_LAST + 1);

endpackage
